// File: design/io_pkg.sv
// shared localparams, register word offsets
// and packed struct types for the AXI4-Lite port and UART bytes
`default_nettype none

package io_pkg;

    // shortened for simulation
    localparam int clks_per_bit = 16;   // clk_cpu cycles per uart bit
    localparam int ticks_per_ms = 50;   // clk_cpu cycles per ms tick

    localparam int rx_fifo_aw = 4;      // 16 entries
    localparam int axil_aw    = 8;
    localparam int axil_dw    = 32;

    // word offsets of the kept registers
    localparam logic [axil_aw-3:0] reg_ms        = 'd0;
    localparam logic [axil_aw-3:0] reg_led       = 'd1;
    localparam logic [axil_aw-3:0] reg_uart_data = 'd2;
    localparam logic [axil_aw-3:0] reg_uart_stat = 'd3;

    localparam logic [1:0] resp_okay = 2'b00;

    typedef struct packed {
        logic               awvalid;
        logic [axil_aw-1:0] awaddr;
        logic               wvalid;
        logic [axil_dw-1:0] wdata;
        logic [3:0]         wstrb;
        logic               bready;
        logic               arvalid;
        logic [axil_aw-1:0] araddr;
        logic               rready;
    } axil_m2s_t;

    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        logic [1:0]         bresp;
        logic               arready;
        logic               rvalid;
        logic [axil_dw-1:0] rdata;
        logic [1:0]         rresp;
    } axil_s2m_t;

    typedef struct packed {
        logic       valid;  // one-cycle strobe
        logic [7:0] data;
    } uart_byte_t;

endpackage

`default_nettype wire

// File: design/ms_timer.sv
// cycle prescaler and free-running millisecond counter
`timescale 1ns/10ps
`default_nettype none

module ms_timer (
    input  wire logic        clk_cpu,
    input  wire logic        rst_n,
    output      logic [31:0] ms_count_o
);
    import io_pkg::*;

    localparam int pw = $clog2(ticks_per_ms);

    logic [pw-1:0] pre_q;
    logic          wrap;

    assign wrap = (pre_q == pw'(ticks_per_ms - 1));

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            pre_q      <= '0;
            ms_count_o <= 32'd0;
        end else begin
            pre_q      <= wrap ? '0 : pre_q + 1'b1;
            ms_count_o <= ms_count_o + {31'd0, wrap};  // one ms per wrap
        end
    end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
// UART receiver: line synchronizer, start-bit centering,
// LSB-first data sampling and stop-bit check
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
    input  wire logic               clk_cpu,
    input  wire logic               rst_n,
    input  wire logic               serial_i,
    output      io_pkg::uart_byte_t byte_o
);
    import io_pkg::*;

    localparam int cw = $clog2(clks_per_bit);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_t;

    rx_state_t     state_q;
    logic [1:0]    sync_q;     // two-flop synchronizer
    logic          rx_s;
    logic [cw-1:0] cnt_q;
    logic [2:0]    bit_q;
    logic [7:0]    shreg;
    logic          valid_q;

    assign rx_s = sync_q[1];

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            sync_q  <= 2'b11;   // idle line is high
            state_q <= st_idle;
            cnt_q   <= '0;
            bit_q   <= 3'd0;
            valid_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], serial_i};
            valid_q <= 1'b0;
            cnt_q   <= cnt_q + 1'b1;
            case (state_q)
                st_idle: begin
                    cnt_q <= '0;
                    if (!rx_s)
                        state_q <= st_start;
                end
                st_start: if (cnt_q == cw'(clks_per_bit / 2 - 1)) begin
                    cnt_q   <= '0;
                    bit_q   <= 3'd0;
                    // glitch shorter than half a bit goes back to idle
                    state_q <= rx_s ? st_idle : st_data;
                end
                st_data: if (cnt_q == cw'(clks_per_bit - 1)) begin
                    cnt_q <= '0;
                    bit_q <= bit_q + 1'b1;
                    if (bit_q == 3'd7)
                        state_q <= st_stop;
                end
                st_stop: if (cnt_q == cw'(clks_per_bit - 1)) begin
                    valid_q <= rx_s;   // framing error drops the byte
                    state_q <= st_idle;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // sample at bit center, LSB first
    always_ff @(posedge clk_cpu) begin
        if (state_q == st_data && cnt_q == cw'(clks_per_bit - 1))
            shreg <= {rx_s, shreg[7:1]};
    end

    assign byte_o.valid = valid_q;
    assign byte_o.data  = shreg;

endmodule

`default_nettype wire

// File: design/uart_tx.sv
// UART transmitter: start bit, eight data bits LSB first,
// stop bit, with busy flag for the whole frame
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
    input  wire logic               clk_cpu,
    input  wire logic               rst_n,
    input  wire io_pkg::uart_byte_t byte_i,
    output      logic               serial_o,
    output      logic               busy_o
);
    import io_pkg::*;

    localparam int cw = $clog2(clks_per_bit);

    logic [9:0]    frame_q;   // stop, data, start
    logic [cw-1:0] cnt_q;
    logic [3:0]    nbit_q;
    logic          busy_q;
    logic          bit_end;

    assign bit_end = (cnt_q == cw'(clks_per_bit - 1));

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            nbit_q <= 4'd0;
        end else if (!busy_q) begin
            cnt_q  <= '0;
            nbit_q <= 4'd0;
            busy_q <= byte_i.valid;
        end else begin
            cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
            if (bit_end) begin
                nbit_q <= nbit_q + 1'b1;
                if (nbit_q == 4'd9)
                    busy_q <= 1'b0;   // end of stop bit
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!busy_q && byte_i.valid)
            frame_q <= {1'b1, byte_i.data, 1'b0};
        else if (busy_q && bit_end)
            frame_q <= {1'b1, frame_q[9:1]};
    end

    assign serial_o = busy_q ? frame_q[0] : 1'b1;
    assign busy_o   = busy_q;

    // controller must hold off new bytes during a frame
    a_no_start_busy: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        !(byte_i.valid && busy_q));

endmodule

`default_nettype wire

// File: design/rx_fifo.sv
// circular byte queue for received characters
// pushes dropped when full, head shown combinationally
`timescale 1ns/10ps
`default_nettype none

module rx_fifo (
    input  wire logic               clk_cpu,
    input  wire logic               rst_n,
    input  wire io_pkg::uart_byte_t push_i,
    input  wire logic               pop_i,
    output      logic [7:0]         head_o,
    output      logic               empty_o
);
    import io_pkg::*;

    localparam int depth = 2 ** rx_fifo_aw;

    logic [7:0]            mem [depth];
    logic [rx_fifo_aw-1:0] wr_ptr;
    logic [rx_fifo_aw-1:0] rd_ptr;
    logic [rx_fifo_aw:0]   count_q;   // occupancy
    logic                  do_push;
    logic                  do_pop;

    assign empty_o = (count_q == '0);
    assign do_push = push_i.valid && (count_q != (rx_fifo_aw + 1)'(depth));
    assign do_pop  = pop_i && !empty_o;
    assign head_o  = mem[rd_ptr];

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count_q <= count_q + {{rx_fifo_aw{1'b0}}, do_push} - {{rx_fifo_aw{1'b0}}, do_pop};
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (do_push)
            mem[wr_ptr] <= push_i.data;
    end

    a_no_pop_empty: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: design/io_regs_ctrl.sv
// AXI4-Lite slave of the I/O block: channel handshakes, offset decode,
// read mux, LED register and UART transmit / dequeue strobes
`timescale 1ns/10ps
`default_nettype none

module io_regs_ctrl (
    input  wire logic               clk_cpu,
    input  wire logic               rst_n,
    input  wire io_pkg::axil_m2s_t  axil_i,
    output      io_pkg::axil_s2m_t  axil_o,
    input  wire logic [31:0]        ms_count_i,
    input  wire logic [7:0]         fifo_head_i,
    input  wire logic               fifo_empty_i,
    input  wire logic               tx_busy_i,
    output      logic               fifo_pop_o,
    output      io_pkg::uart_byte_t tx_byte_o,
    output      logic [7:0]         led_o
);
    import io_pkg::*;

    logic [axil_aw-3:0] wr_off;
    logic [axil_aw-3:0] rd_off;
    logic               wr_fire;
    logic               rd_fire;
    logic               bvalid_q;
    logic               rvalid_q;
    logic [axil_dw-1:0] rd_mux;
    logic [axil_dw-1:0] rdata_q;
    logic [7:0]         rx_data_q;   // last dequeued byte
    logic [7:0]         tx_data_q;
    logic               tx_start_q;
    logic               pop_q;
    logic               tx_ready;

    assign wr_off = axil_i.awaddr[axil_aw-1:2];
    assign rd_off = axil_i.araddr[axil_aw-1:2];

    // address and data taken together, only with no response pending
    assign wr_fire = axil_i.awvalid && axil_i.wvalid && !bvalid_q;
    assign rd_fire = axil_i.arvalid && !rvalid_q;

    // a start still on its way to the transmitter counts as busy
    assign tx_ready = !tx_busy_i && !tx_start_q;

    always_comb begin
        case (rd_off)
            reg_ms:        rd_mux = ms_count_i;
            reg_led:       rd_mux = '0;   // write-only
            reg_uart_data: rd_mux = {24'd0, rx_data_q};
            reg_uart_stat: rd_mux = {30'd0, tx_ready, !fifo_empty_i};
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            led_o      <= 8'd0;
            tx_start_q <= 1'b0;
            pop_q      <= 1'b0;
            rx_data_q  <= 8'd0;
        end else begin
            tx_start_q <= 1'b0;
            pop_q      <= 1'b0;
            if (wr_fire)
                bvalid_q <= 1'b1;
            else if (axil_i.bready)
                bvalid_q <= 1'b0;
            if (rd_fire)
                rvalid_q <= 1'b1;
            else if (axil_i.rready)
                rvalid_q <= 1'b0;

            if (wr_fire) begin
                if (wr_off == reg_led && axil_i.wstrb[0])
                    led_o <= axil_i.wdata[7:0];
                if (wr_off == reg_uart_data && tx_ready)
                    tx_start_q <= 1'b1;   // dropped when busy
                if (wr_off == reg_uart_stat && !fifo_empty_i)
                    pop_q <= 1'b1;
            end
            if (pop_q)
                rx_data_q <= fifo_head_i;   // head before the pop takes effect
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (rd_fire)
            rdata_q <= rd_mux;
        if (wr_fire && wr_off == reg_uart_data)
            tx_data_q <= axil_i.wdata[7:0];
    end

    always_comb begin
        axil_o         = '0;
        axil_o.awready = wr_fire;
        axil_o.wready  = wr_fire;
        axil_o.bvalid  = bvalid_q;
        axil_o.bresp   = resp_okay;
        axil_o.arready = rd_fire;
        axil_o.rvalid  = rvalid_q;
        axil_o.rdata   = rdata_q;
        axil_o.rresp   = resp_okay;
    end

    assign fifo_pop_o      = pop_q;
    assign tx_byte_o.valid = tx_start_q;
    assign tx_byte_o.data  = tx_data_q;

    // responses hold until the master takes them
    a_bvalid_hold: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        bvalid_q && !axil_i.bready |=> bvalid_q);
    a_rvalid_hold: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        rvalid_q && !axil_i.rready |=> rvalid_q && $stable(rdata_q));

endmodule

`default_nettype wire

// File: design/io_top.sv
// top level of the I/O block: register controller, ms timer,
// UART receiver with its queue, UART transmitter
`timescale 1ns/10ps
`default_nettype none

module io_top (
    input  wire logic              clk_cpu,
    input  wire logic              rst_n,
    input  wire io_pkg::axil_m2s_t axil_i,
    output      io_pkg::axil_s2m_t axil_o,
    input  wire logic              uart_rx_i,
    output      logic              uart_tx_o,
    output      logic [7:0]        led_o
);
    import io_pkg::*;

    logic [31:0] ms_count;
    logic [7:0]  fifo_head;
    logic        fifo_empty;
    logic        fifo_pop;
    logic        tx_busy;
    uart_byte_t  rx_byte;    // receiver to queue
    uart_byte_t  tx_byte;    // controller to transmitter

    io_regs_ctrl io_regs_ctrl_i (
        .clk_cpu      (clk_cpu),
        .rst_n        (rst_n),
        .axil_i       (axil_i),
        .axil_o       (axil_o),
        .ms_count_i   (ms_count),
        .fifo_head_i  (fifo_head),
        .fifo_empty_i (fifo_empty),
        .tx_busy_i    (tx_busy),
        .fifo_pop_o   (fifo_pop),
        .tx_byte_o    (tx_byte),
        .led_o        (led_o)
    );

    ms_timer ms_timer_i (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    uart_rx uart_rx_i0 (
        .clk_cpu  (clk_cpu),
        .rst_n    (rst_n),
        .serial_i (uart_rx_i),
        .byte_o   (rx_byte)
    );

    rx_fifo rx_fifo_i (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .push_i  (rx_byte),
        .pop_i   (fifo_pop),
        .head_o  (fifo_head),
        .empty_o (fifo_empty)
    );

    uart_tx uart_tx_i0 (
        .clk_cpu  (clk_cpu),
        .rst_n    (rst_n),
        .byte_i   (tx_byte),
        .serial_o (uart_tx_o),
        .busy_o   (tx_busy)
    );

endmodule

`default_nettype wire

// File: tb/axil_tasks.svh
// AXI4-Lite register write and read tasks with random response stalls,
// and the LCG that supplies the random numbers
`ifndef AXIL_TASKS_SVH
`define AXIL_TASKS_SVH

logic [31:0] lcg_state = lcg_seed;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// mostly zero, now and then 1 to 4 cycles of held-off ready
function automatic int stall_cycles();
    logic [31:0] r;
    int          n;
    r = next_rand();
    n = (r[31:30] == 2'b00) ? int'(r[27:26]) + 1 : 0;
    return (n < min_stall) ? min_stall : n;
endfunction

task automatic write_reg(input logic [5:0] off, input logic [31:0] data,
                         input logic [3:0] strb);
    int hold;
    hold = stall_cycles();
    @(posedge clk_cpu);
    axil_m.awvalid <= 1'b1;
    axil_m.awaddr  <= {off, 2'b00};
    axil_m.wvalid  <= 1'b1;
    axil_m.wdata   <= data;
    axil_m.wstrb   <= strb;
    do begin
        @(posedge clk_cpu);
    end while (!axil_s.awready);
    axil_m.awvalid <= 1'b0;
    axil_m.wvalid  <= 1'b0;
    repeat (hold) @(posedge clk_cpu);
    axil_m.bready <= 1'b1;
    do begin
        @(posedge clk_cpu);
    end while (!axil_s.bvalid);
    axil_m.bready <= 1'b0;
    if (axil_s.bresp !== resp_okay)
        report_mismatch("bresp", 32'(axil_s.bresp), 32'(resp_okay));
endtask

task automatic read_reg(input logic [5:0] off, input logic check, output logic [31:0] data);
    int hold;
    hold = stall_cycles();
    @(posedge clk_cpu);
    rd_check  = check;
    rd_expect = expect_rdata(off);   // model state at issue time
    axil_m.arvalid <= 1'b1;
    axil_m.araddr  <= {off, 2'b00};
    do begin
        @(posedge clk_cpu);
    end while (!axil_s.arready);
    rd_accept_cyc = cycle_cnt;
    axil_m.arvalid <= 1'b0;
    repeat (hold) @(posedge clk_cpu);
    axil_m.rready <= 1'b1;
    do begin
        @(posedge clk_cpu);
    end while (!axil_s.rvalid);
    data = axil_s.rdata;
    axil_m.rready <= 1'b0;
endtask

`endif

// File: tb/tb_io_top.sv
// testbench for the I/O block: register tests over AXI4-Lite, UART loopback,
// register map model with read-data compare, timeout and summary
`timescale 1ns/10ps
`default_nettype none

module tb_io_top;
    import io_pkg::*;

    localparam logic [31:0] lcg_seed = 32'd24;
    localparam int frame_cycles = 10 * clks_per_bit;
    localparam int timer_gap    = 4 * ticks_per_ms;   // plus up to 31 random cycles
    localparam int cycle_limit  = 8 * frame_cycles + 2 * (timer_gap + 32) + 4000;
    localparam int poll_limit   = 100;

    logic       clk_cpu;
    logic       rst_n;
    axil_m2s_t  axil_m;
    axil_s2m_t  axil_s;
    wire        uart_line;   // tx looped back into rx
    logic [7:0] led;

    int          cycle_cnt;
    int          err_cnt   = 0;
    int          err_mark  = 0;
    int          tests_run = 0;
    int          min_stall = 0;
    int          rd_accept_cyc;
    logic        rd_check  = 1'b0;
    logic [31:0] rd_expect;

    // register map model
    logic [7:0] m_led      = 8'd0;
    logic [7:0] m_rx_data  = 8'd0;
    logic       m_tx_ready = 1'b1;
    logic       m_rx_avail = 1'b0;

    io_top io_top_i (
        .clk_cpu   (clk_cpu),
        .rst_n     (rst_n),
        .axil_i    (axil_m),
        .axil_o    (axil_s),
        .uart_rx_i (uart_line),
        .uart_tx_o (uart_line),
        .led_o     (led)
    );

    initial begin
        clk_cpu = 1'b0;
        forever #10 clk_cpu = ~clk_cpu;
    end

    always @(posedge clk_cpu) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: tests still running after %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        err_cnt++;
    endtask

    // expected read data; the ms counter is range-checked in its own test
    function automatic logic [31:0] expect_rdata(input logic [5:0] off);
        logic [31:0] v;
        case (off)
            reg_led:       v = 32'd0;
            reg_uart_data: v = {24'd0, m_rx_data};
            reg_uart_stat: v = {30'd0, m_tx_ready, m_rx_avail};
            default:       v = 32'd0;
        endcase
        return v;
    endfunction

    `include "axil_tasks.svh"

    // checked reads compared when the data is taken
    always @(posedge clk_cpu) begin
        if (rd_check && axil_s.rvalid && axil_m.rready) begin
            if (axil_s.rdata !== rd_expect)
                report_mismatch("rdata", axil_s.rdata, rd_expect);
            if (axil_s.rresp !== resp_okay)
                report_mismatch("rresp", 32'(axil_s.rresp), 32'(resp_okay));
        end
    end

    task automatic poll_status(input int bit_idx);
        logic [31:0] st;
        int          tries;
        st    = 32'd0;
        tries = 0;
        while (!st[bit_idx] && tries < poll_limit) begin
            read_reg(reg_uart_stat, 1'b0, st);
            tries++;
        end
        if (!st[bit_idx]) begin
            $display("status bit %0d still clear after %0d reads", bit_idx, tries);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        @(posedge clk_cpu);   // let the last compare run
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] r;
        logic [31:0] ms_a;
        logic [31:0] ms_b;
        logic [7:0]  sent_q[$];
        logic [5:0]  off;
        int          i;
        int          cyc_a;
        int          lo;

        axil_m <= '0;
        rst_n  <= 1'b0;
        repeat (2) @(posedge clk_cpu);
        rst_n <= 1'b1;
        @(posedge clk_cpu);

        if (led !== 8'd0)
            report_mismatch("led_o", 32'(led), 32'd0);
        if (uart_line !== 1'b1)
            report_mismatch("uart_tx_o", 32'(uart_line), 32'd1);
        if ({axil_s.awready, axil_s.wready, axil_s.bvalid, axil_s.arready, axil_s.rvalid} != 0)
            report_mismatch("ready_valid", 32'({axil_s.awready, axil_s.wready,
                            axil_s.bvalid, axil_s.arready, axil_s.rvalid}), 32'd0);
        read_reg(reg_uart_stat, 1'b1, rd);
        end_test("reset state");

        for (i = 0; i < 4; i++) begin
            r = next_rand();
            write_reg(reg_led, {24'd0, r[23:16]}, 4'b0001);
            m_led = r[23:16];
            if (led !== m_led)
                report_mismatch("led_o", 32'(led), 32'(m_led));
        end
        write_reg(reg_led, {24'hffffff, ~m_led}, 4'b1110);   // byte 0 strobe clear
        if (led !== m_led)
            report_mismatch("led_o", 32'(led), 32'(m_led));
        read_reg(reg_led, 1'b1, rd);
        end_test("leds");

        for (i = 0; i < 2; i++) begin
            read_reg(reg_ms, 1'b0, ms_a);
            cyc_a = rd_accept_cyc;
            r = next_rand();
            repeat (timer_gap + int'(r[20:16])) @(posedge clk_cpu);
            read_reg(reg_ms, 1'b0, ms_b);
            lo = (rd_accept_cyc - cyc_a) / ticks_per_ms;
            if (ms_b - ms_a < 32'(lo) || ms_b - ms_a > 32'(lo + 1)) begin
                $display("Mismatch at %0t: ms_count delta = %0d, expected %0d or %0d",
                         $time, ms_b - ms_a, lo, lo + 1);
                err_cnt++;
            end
        end
        end_test("ms timer");

        for (i = 0; i < 3; i++) begin
            r = next_rand();
            write_reg(reg_uart_data, {24'd0, r[23:16]}, 4'hf);
            sent_q.push_back(r[23:16]);
            poll_status(1);   // frame sent
            poll_status(0);   // byte back in the queue
            write_reg(reg_uart_stat, 32'd0, 4'hf);
            m_rx_data = sent_q.pop_front();
            read_reg(reg_uart_data, 1'b1, rd);
        end
        read_reg(reg_uart_stat, 1'b1, rd);
        end_test("uart loopback");

        min_stall = 3;
        read_reg(reg_led, 1'b1, rd);
        read_reg(reg_uart_data, 1'b1, rd);
        read_reg(reg_uart_stat, 1'b1, rd);
        for (off = 6'd4; off <= 6'd15; off++) begin
            write_reg(off, next_rand(), 4'hf);
            read_reg(off, 1'b1, rd);
        end
        if (led !== m_led)
            report_mismatch("led_o", 32'(led), 32'(m_led));
        if (uart_line !== 1'b1)
            report_mismatch("uart_tx_o", 32'(uart_line), 32'd1);
        read_reg(reg_uart_data, 1'b1, rd);
        read_reg(reg_uart_stat, 1'b1, rd);
        min_stall = 0;
        end_test("backpressure and unmapped");

        $display("%0d tests run, %0d errors", tests_run, err_cnt);
        if (err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+tb
design/io_pkg.sv
design/ms_timer.sv
design/uart_rx.sv
design/uart_tx.sv
design/rx_fifo.sv
design/io_regs_ctrl.sv
design/io_top.sv
tb/tb_io_top.sv

// File: Makefile
# Verilator lint and simulation of the I/O block testbench

VERILATOR ?= verilator
TOP       ?= tb_io_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
